//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 32;

    typedef logic [XLEN-1:0]      word_t;    // Data word or address
    typedef logic [31:0]          inst_t;    // Raw instruction word
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Base opcodes of RV32I
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // addi x0, x0, 0
    localparam inst_t INST_NOP = 32'h0000_0013;

    // PC bit that maps fetch onto the boot ROM
    localparam int BIOS_PC_BIT = 30;

endpackage

//--- src/id_sel_pkg.sv
package id_sel_pkg;

    // Immediate layouts, codes 6 and 7 are unused
    typedef enum logic [2:0] {
        IMM_I    = 3'd0,
        IMM_S    = 3'd1,
        IMM_B    = 3'd2,
        IMM_U    = 3'd3,
        IMM_J    = 3'd4,
        IMM_NONE = 3'd5
    } imm_fmt_t;

    typedef enum logic [1:0] {
        TGT_NONE   = 2'd0,
        TGT_JAL    = 2'd1,
        TGT_JALR   = 2'd2,
        TGT_BRANCH = 2'd3
    } tgt_kind_t;

    // Source of the jalr base register
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_EX  = 2'd1,
        FWD_MEM = 2'd2,
        FWD_WB  = 2'd3
    } fwd_sel_t;

    typedef enum logic {
        SRC_IMEM = 1'b0,
        SRC_BIOS = 1'b1
    } inst_src_t;

endpackage

//--- src/inst_decode.sv
module inst_decode import rv_isa_pkg::*; import id_sel_pkg::*; (
    input  word_t    pc,
    input  inst_t    bios_inst,
    input  inst_t    imem_inst,
    input  imm_fmt_t imm_fmt,
    output inst_t    inst,
    output reg_idx_t ra1,
    output reg_idx_t ra2,
    output word_t    imm
);

    inst_src_t inst_src;
    logic      sign;

    assign inst_src = pc[BIOS_PC_BIT] ? SRC_BIOS : SRC_IMEM;
    assign inst     = (inst_src == SRC_BIOS) ? bios_inst : imem_inst;

    assign ra1  = inst[19:15]; // rs1
    assign ra2  = inst[24:20]; // rs2
    assign sign = inst[31];

    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                imm = {{20{sign}}, inst[31:20]};
            end
            IMM_S: begin
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            end
            IMM_B: begin
                // Halfword offset so bit 0 is always zero
                imm = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {inst[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0; // R-type has no immediate
            end
        endcase
    end

    // id_control only ever requests one of the six defined formats
    always_comb begin
        assert final (imm_fmt inside {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_NONE})
            else $error("inst_decode: unused immediate format %0d", imm_fmt);
    end

endmodule

//--- src/reg_file.sv
module reg_file import rv_isa_pkg::*; (
    input            clk,
    input            we,
    input  reg_idx_t ra1,
    input  reg_idx_t ra2,
    input  reg_idx_t wa,
    input  word_t    wd,
    output word_t    rd1,
    output word_t    rd2
);

    word_t regs [NUM_REGS];
    logic  wr_ok;

    assign wr_ok = we && (wa != '0); // x0 is never written

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write is visible on the read ports
    assign rd1 = (ra1 == '0)              ? '0 :
                 (wr_ok && (wa == ra1))   ? wd : regs[ra1];
    assign rd2 = (ra2 == '0)              ? '0 :
                 (wr_ok && (wa == ra2))   ? wd : regs[ra2];

    // Stored value comes back from the array one cycle after the write
    wr_back_a: assert property (@(posedge clk) wr_ok |=>
        ((ra1 != $past(wa)) || (wr_ok && (wa == ra1)) || (rd1 == $past(wd))))
        else $error("reg_file: written value not read back");

endmodule

//--- src/id_control.sv
module id_control import rv_isa_pkg::*; import id_sel_pkg::*; (
    input  inst_t     inst,
    input  inst_t     ex_inst,
    input  inst_t     mem_inst,
    input  inst_t     wb_inst,
    input             wb_regwen,
    output imm_fmt_t  imm_fmt,
    output tgt_kind_t tgt_kind,
    output fwd_sel_t  fwd_sel
);

    reg_idx_t rs1;
    reg_idx_t ex_rd;
    reg_idx_t mem_rd;
    reg_idx_t wb_rd;

    // Branches and stores have no destination register
    function automatic logic writes_rd(inst_t i);
        return (i[6:0] != OP_BRANCH) && (i[6:0] != OP_STORE);
    endfunction

    assign rs1    = inst[19:15];
    assign ex_rd  = ex_inst[11:7];
    assign mem_rd = mem_inst[11:7];
    assign wb_rd  = wb_inst[11:7];

    always_comb begin
        imm_fmt  = IMM_NONE;
        tgt_kind = TGT_NONE;
        case (inst[6:0])
            OP_LUI, OP_AUIPC:        imm_fmt = IMM_U;
            OP_JAL: begin
                imm_fmt  = IMM_J;
                tgt_kind = TGT_JAL;
            end
            OP_JALR: begin
                imm_fmt  = IMM_I;
                tgt_kind = TGT_JALR;
            end
            OP_BRANCH: begin
                imm_fmt  = IMM_B;
                tgt_kind = TGT_BRANCH;
            end
            OP_LOAD, OP_IMM:         imm_fmt = IMM_I;
            OP_STORE:                imm_fmt = IMM_S;
            default:                 imm_fmt = IMM_NONE; // R-type and unknown
        endcase
    end

    // Youngest producer wins
    always_comb begin
        fwd_sel = FWD_RF;
        if ((tgt_kind == TGT_JALR) && (rs1 != '0)) begin
            if (writes_rd(ex_inst) && (ex_rd == rs1)) begin
                fwd_sel = FWD_EX;
            end else if (writes_rd(mem_inst) && (mem_rd == rs1)) begin
                fwd_sel = FWD_MEM;
            end else if (wb_regwen && (wb_rd == rs1)) begin
                fwd_sel = FWD_WB;
            end
        end
    end

    always_comb begin
        assert final ((tgt_kind == TGT_JALR) || (fwd_sel == FWD_RF))
            else $error("id_control: forwarding selected outside jalr");
    end

endmodule

//--- src/target_gen.sv
module target_gen import rv_isa_pkg::*; import id_sel_pkg::*; (
    input  word_t     pc,
    input  word_t     rd1,
    input  word_t     ex_alu,
    input  word_t     mem_alu,
    input  word_t     wb_wdata,
    input  word_t     imm,
    input  tgt_kind_t tgt_kind,
    input  fwd_sel_t  fwd_sel,
    output word_t     target,
    output logic      target_taken,
    output logic      br_pred
);

    word_t base;
    word_t jalr_sum;
    logic  backward;

    always_comb begin
        case (fwd_sel)
            FWD_EX:  base = ex_alu;
            FWD_MEM: base = mem_alu;
            FWD_WB:  base = wb_wdata;
            default: base = rd1;
        endcase
    end

    assign jalr_sum = base + imm;
    assign backward = imm[31]; // Negative offset

    always_comb begin
        case (tgt_kind)
            TGT_JAL: begin
                target       = pc + imm;
                target_taken = 1'b1;
            end
            TGT_JALR: begin
                target       = {jalr_sum[31:1], 1'b0};
                target_taken = 1'b1;
            end
            TGT_BRANCH: begin
                target       = pc + imm;
                target_taken = backward; // Backward taken, forward not taken
            end
            default: begin
                target       = pc + 32'd4;
                target_taken = 1'b0;
            end
        endcase
    end

    assign br_pred = (tgt_kind == TGT_BRANCH) && backward;

endmodule

//--- src/id_ex_reg.sv
module id_ex_reg import rv_isa_pkg::*; #(
    parameter type      payload_t = word_t,
    parameter payload_t BUBBLE    = '0
) (
    input            clk,
    input            rst_n,
    input            stall,
    input            flush,
    input  payload_t d,
    output payload_t q
);

    // Reset beats flush, flush beats stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= BUBBLE;
        end else if (flush) begin
            q <= BUBBLE;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

//--- src/id_stage.sv
module id_stage import rv_isa_pkg::*; import id_sel_pkg::*; (
    input         clk,
    input         rst_n,
    input         stall,
    input         flush,
    input  word_t id_pc,
    input  inst_t id_bios_inst,
    input  inst_t id_imem_inst,
    input         wb_regwen,
    input  word_t wb_wdata,
    input  word_t ex_alu,            // Forwarding candidates for jalr
    input  word_t mem_alu,
    input  inst_t mem_inst,
    input  inst_t wb_inst,           // Also carries the write index
    output word_t if_pc_target,
    output logic  if_target_taken,
    output logic  ex_br_taken,
    output word_t ex_pc,
    output word_t ex_rd1,
    output word_t ex_rd2,
    output word_t ex_imm,
    output inst_t ex_inst
);

    inst_t     inst;
    reg_idx_t  ra1;
    reg_idx_t  ra2;
    word_t     imm;
    word_t     rd1;
    word_t     rd2;
    imm_fmt_t  imm_fmt_req;
    tgt_kind_t tgt_kind;
    fwd_sel_t  fwd_sel;
    logic      br_pred;

    inst_decode inst_decode_i (
        .pc(id_pc), .bios_inst(id_bios_inst), .imem_inst(id_imem_inst),
        .imm_fmt(imm_fmt_req),
        .inst(inst), .ra1(ra1), .ra2(ra2), .imm(imm)
    );

    reg_file reg_file_i (
        .clk(clk), .we(wb_regwen),
        .ra1(ra1), .ra2(ra2), .wa(wb_inst[11:7]), .wd(wb_wdata),
        .rd1(rd1), .rd2(rd2)
    );

    id_control id_control_i (
        .inst(inst), .ex_inst(ex_inst), .mem_inst(mem_inst), .wb_inst(wb_inst),
        .wb_regwen(wb_regwen),
        .imm_fmt(imm_fmt_req), .tgt_kind(tgt_kind), .fwd_sel(fwd_sel)
    );

    target_gen target_gen_i (
        .pc(id_pc), .rd1(rd1), .ex_alu(ex_alu), .mem_alu(mem_alu), .wb_wdata(wb_wdata),
        .imm(imm), .tgt_kind(tgt_kind), .fwd_sel(fwd_sel),
        .target(if_pc_target), .target_taken(if_target_taken), .br_pred(br_pred)
    );

    // ID/EX boundary
    id_ex_reg #(.payload_t(word_t)) pc_reg (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .d(id_pc), .q(ex_pc)
    );
    id_ex_reg #(.payload_t(word_t)) rd1_reg (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .d(rd1), .q(ex_rd1)
    );
    id_ex_reg #(.payload_t(word_t)) rd2_reg (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .d(rd2), .q(ex_rd2)
    );
    id_ex_reg #(.payload_t(word_t)) imm_reg (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .d(imm), .q(ex_imm)
    );
    id_ex_reg #(.payload_t(inst_t), .BUBBLE(INST_NOP)) inst_reg (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .d(inst), .q(ex_inst)
    );
    id_ex_reg #(.payload_t(logic), .BUBBLE(1'b0)) br_pred_reg (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .d(br_pred), .q(ex_br_taken)
    );

endmodule

//--- verif/id_stage_tb.sv
module id_stage_tb import rv_isa_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 2000;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_TESTS + 100;

    logic  clk = 1'b0;
    logic  rst_n, stall, flush, wb_regwen;
    word_t id_pc, wb_wdata, ex_alu, mem_alu;
    inst_t id_bios_inst, id_imem_inst, mem_inst, wb_inst;
    word_t if_pc_target, ex_pc, ex_rd1, ex_rd2, ex_imm;
    logic  if_target_taken, ex_br_taken;
    inst_t ex_inst;

    // Reference model state
    word_t mirror [NUM_REGS];
    word_t exp_pc, exp_rd1, exp_rd2, exp_imm;    // Expected ID/EX contents
    inst_t exp_inst;
    logic  exp_br;
    word_t nxt_pc, nxt_rd1, nxt_rd2, nxt_imm;    // Decoded values for the next edge
    inst_t nxt_inst;
    logic  nxt_br;
    int    error_count = 0;
    int    cycles = 0;

    id_stage id_stage_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "run stopped at first error");
        end
    endtask

    task automatic check_inst(string name, inst_t expected, inst_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "run stopped at first error");
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "run stopped at first error");
        end
    endtask

    function automatic inst_t random_inst();
        inst_t i;
        i = $urandom;
        case (4'($urandom % 9))
            4'd0:    i[6:0] = OP_LUI;
            4'd1:    i[6:0] = OP_AUIPC;
            4'd2:    i[6:0] = OP_JAL;
            4'd3:    i[6:0] = OP_JALR;
            4'd4:    i[6:0] = OP_BRANCH;
            4'd5:    i[6:0] = OP_LOAD;
            4'd6:    i[6:0] = OP_STORE;
            4'd7:    i[6:0] = OP_IMM;
            default: i[6:0] = OP_REG;
        endcase
        i[11:7]  = 5'($urandom % 8); // Few indices so hazards come often
        i[19:15] = 5'($urandom % 8);
        return i;
    endfunction

    // Immediate as laid out by the RV32I formats
    function automatic word_t imm_of(inst_t i);
        case (i[6:0])
            OP_JALR, OP_LOAD, OP_IMM: return {{20{i[31]}}, i[31:20]};
            OP_STORE:                 return {{20{i[31]}}, i[31:25], i[11:7]};
            OP_BRANCH:                return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            OP_LUI, OP_AUIPC:         return {i[31:12], 12'h000};
            OP_JAL:                   return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            default:                  return '0;
        endcase
    endfunction

    function automatic word_t reg_read(reg_idx_t idx);
        if (idx == '0) return '0;
        if (wb_regwen && wb_inst[11:7] == idx) return wb_wdata; // Write-through
        return mirror[idx];
    endfunction

    function automatic logic has_dest(inst_t i);
        return i[6:0] != OP_BRANCH && i[6:0] != OP_STORE;
    endfunction

    // Youngest writer of rs1 supplies the jalr base
    function automatic word_t jalr_base(reg_idx_t rs1);
        if (rs1 == '0) return '0;
        if (has_dest(exp_inst) && exp_inst[11:7] == rs1) return ex_alu;
        if (has_dest(mem_inst) && mem_inst[11:7] == rs1) return mem_alu;
        if (wb_regwen && wb_inst[11:7] == rs1) return wb_wdata;
        return mirror[rs1];
    endfunction

    task automatic next_edge();
        @(posedge clk);
        if (wb_regwen && wb_inst[11:7] != '0) mirror[wb_inst[11:7]] = wb_wdata;
        if (!rst_n || flush) begin
            exp_pc   = '0;
            exp_rd1  = '0;
            exp_rd2  = '0;
            exp_imm  = '0;
            exp_inst = INST_NOP;
            exp_br   = 1'b0;
        end else if (!stall) begin
            exp_pc   = nxt_pc;
            exp_rd1  = nxt_rd1;
            exp_rd2  = nxt_rd2;
            exp_imm  = nxt_imm;
            exp_inst = nxt_inst;
            exp_br   = nxt_br;
        end
    endtask

    task automatic check_outputs(string phase);
        word_t target;
        logic  taken;
        @(negedge clk);
        nxt_inst = id_pc[BIOS_PC_BIT] ? id_bios_inst : id_imem_inst;
        nxt_pc   = id_pc;
        nxt_imm  = imm_of(nxt_inst);
        nxt_rd1  = reg_read(nxt_inst[19:15]);
        nxt_rd2  = reg_read(nxt_inst[24:20]);
        nxt_br   = nxt_inst[6:0] == OP_BRANCH && nxt_imm[31];
        taken    = 1'b1;
        target   = id_pc + nxt_imm;
        if (nxt_inst[6:0] == OP_JALR) begin
            target = (jalr_base(nxt_inst[19:15]) + nxt_imm) & ~32'd1;
        end else if (nxt_inst[6:0] == OP_BRANCH) begin
            taken = nxt_br; // Only backward branches
        end else if (nxt_inst[6:0] != OP_JAL) begin
            taken  = 1'b0;
            target = id_pc + 32'd4;
        end
        check_word({phase, " if_pc_target"}, target, if_pc_target);
        check_bit({phase, " if_target_taken"}, taken, if_target_taken);
        check_word({phase, " ex_pc"}, exp_pc, ex_pc);
        check_word({phase, " ex_rd1"}, exp_rd1, ex_rd1);
        check_word({phase, " ex_rd2"}, exp_rd2, ex_rd2);
        check_word({phase, " ex_imm"}, exp_imm, ex_imm);
        check_inst({phase, " ex_inst"}, exp_inst, ex_inst);
        check_bit({phase, " ex_br_taken"}, exp_br, ex_br_taken);
    endtask

    task automatic drive_quiet();
        stall        <= 1'b0;
        flush        <= 1'b0;
        wb_regwen    <= 1'b0;
        id_pc        <= '0;
        id_bios_inst <= INST_NOP;
        id_imem_inst <= INST_NOP;
        mem_inst     <= INST_NOP;
        wb_inst      <= INST_NOP;
        wb_wdata     <= '0;
        ex_alu       <= '0;
        mem_alu      <= '0;
    endtask

    task automatic drive_preload(int r);
        drive_quiet();
        wb_regwen <= 1'b1;
        wb_inst   <= {20'h0, 5'(r), OP_IMM};
        wb_wdata  <= $urandom;
    endtask

    task automatic drive_random();
        stall        <= ($urandom % 4) == 0;
        flush        <= ($urandom % 8) == 0;
        wb_regwen    <= ($urandom % 2) == 0;
        id_pc        <= $urandom; // Bit 30 picks the boot ROM
        id_bios_inst <= random_inst();
        id_imem_inst <= random_inst();
        mem_inst     <= random_inst();
        wb_inst      <= random_inst();
        wb_wdata     <= $urandom;
        ex_alu       <= $urandom;
        mem_alu      <= $urandom;
    endtask

    initial begin
        int seed_ret;
        seed_ret = $urandom(32'hbe93);
        rst_n <= 1'b0;
        drive_quiet();
        repeat (RESET_CYCLES - 1) begin
            next_edge();
            check_outputs("reset");
        end
        next_edge();
        rst_n <= 1'b1;
        check_outputs("release");
        check_inst("reset ex_inst", INST_NOP, ex_inst);
        check_bit("reset ex_br_taken", 1'b0, ex_br_taken);
        // Fill every register so reads are known
        for (int r = 1; r < NUM_REGS; r++) begin
            next_edge();
            drive_preload(r);
            check_outputs("preload");
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            next_edge();
            drive_random();
            check_outputs("random");
        end
        next_edge();
        check_outputs("drain");
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- id_stage.f
src/rv_isa_pkg.sv
src/id_sel_pkg.sv
src/inst_decode.sv
src/reg_file.sv
src/id_control.sv
src/target_gen.sv
src/id_ex_reg.sv
src/id_stage.sv
verif/id_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= id_stage_tb
FILELIST  ?= id_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
